//--- design/dsp_bus_decode.sv
// Address decoder that steers the master strobe to one filter and muxes the reply back
`default_nettype none

module dsp_bus_decode (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  dsp_bus_pkg::wb_addr_t wb_adr_i,
   input  dsp_bus_pkg::wb_data_t wb_dat_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   output dsp_bus_pkg::wb_data_t wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  wb_err_o,
   wb_slave_if.bus               fir_o,
   wb_slave_if.bus               iir_o
);

   logic [dsp_bus_pkg::RANGE_WIDTH-1:0] range;
   dsp_bus_pkg::slave_sel_t             sel;
   logic                                err_q;

   assign range = wb_adr_i[dsp_bus_pkg::WB_AW-1 -: dsp_bus_pkg::RANGE_WIDTH];

   always_comb begin
      case (range)
         dsp_bus_pkg::FIR_RANGE_MATCH: sel = dsp_bus_pkg::SEL_FIR;
         dsp_bus_pkg::IIR_RANGE_MATCH: sel = dsp_bus_pkg::SEL_IIR;
         default:                      sel = dsp_bus_pkg::SEL_NONE;
      endcase
   end

   // Request lines go to both slaves, only stb is qualified
   assign fir_o.adr   = wb_adr_i;
   assign fir_o.dat_w = wb_dat_i;
   assign fir_o.cyc   = wb_cyc_i;
   assign fir_o.we    = wb_we_i;
   assign fir_o.stb   = wb_stb_i && (sel == dsp_bus_pkg::SEL_FIR);

   assign iir_o.adr   = wb_adr_i;
   assign iir_o.dat_w = wb_dat_i;
   assign iir_o.cyc   = wb_cyc_i;
   assign iir_o.we    = wb_we_i;
   assign iir_o.stb   = wb_stb_i && (sel == dsp_bus_pkg::SEL_IIR);

   // Unmapped access answers like a slave, one cycle after the strobe
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wb_cyc_i && wb_stb_i && (sel == dsp_bus_pkg::SEL_NONE) && !err_q;
      end
   end

   always_comb begin
      case (sel)
         dsp_bus_pkg::SEL_FIR: begin
            wb_dat_o = fir_o.dat_r;
            wb_ack_o = fir_o.ack;
            wb_err_o = fir_o.err;
         end
         dsp_bus_pkg::SEL_IIR: begin
            wb_dat_o = iir_o.dat_r;
            wb_ack_o = iir_o.ack;
            wb_err_o = iir_o.err;
         end
         default: begin
            wb_dat_o = '0;                            // Nothing to read back
            wb_ack_o = 1'b0;
            wb_err_o = err_q;
         end
      endcase
   end

   a_ack_err_excl : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(wb_ack_o && wb_err_o));

   // Filters never raise err, so err must come from an unmapped strobe
   a_err_unmapped : assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_err_o |-> $past(wb_cyc_i && wb_stb_i && (sel == dsp_bus_pkg::SEL_NONE)));

endmodule

`default_nettype wire

//--- design/dsp_bus_pkg.sv
// Bus widths, address map and decoded target type used by every module of the DSP tile
`default_nettype none

package dsp_bus_pkg;

   localparam int WB_AW       = 32;                   // Byte address width
   localparam int WB_DW       = 32;                   // Only full word accesses
   localparam int RANGE_WIDTH = 4;                    // Top address bits compared

   // Filter windows sit at the top of the address space
   localparam logic [RANGE_WIDTH-1:0] FIR_RANGE_MATCH = 4'hf;  // 0xf0000000 window
   localparam logic [RANGE_WIDTH-1:0] IIR_RANGE_MATCH = 4'he;  // 0xe0000000 window

   typedef logic [WB_AW-1:0] wb_addr_t;
   typedef logic [WB_DW-1:0] wb_data_t;

   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,                                // Unmapped address gets err from the decoder
      SEL_FIR  = 2'd1,
      SEL_IIR  = 2'd2
   } slave_sel_t;

endpackage

`default_nettype wire

//--- design/dsp_filter_pkg.sv
// Sample, coefficient and result types plus register offsets of the FIR and IIR slaves
`default_nettype none

package dsp_filter_pkg;

   localparam int SAMPLE_W = 16;
   localparam int COEF_W   = 16;
   localparam int ACC_W    = 32;

   localparam int FIR_TAPS      = 4;
   localparam int IIR_FRAC_BITS = 15;                 // Q15 feedback coefficient

   // Register index lives in byte address bits 4..2
   localparam int OFS_MSB = 4;
   localparam int OFS_LSB = 2;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COEF_W-1:0]   coef_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic [OFS_MSB:0]           reg_ofs_t;     // Byte offset inside a window

   localparam reg_ofs_t FIR_OFS_COEF0  = 5'h00;
   localparam reg_ofs_t FIR_OFS_COEF1  = 5'h04;
   localparam reg_ofs_t FIR_OFS_COEF2  = 5'h08;
   localparam reg_ofs_t FIR_OFS_COEF3  = 5'h0c;
   localparam reg_ofs_t FIR_OFS_SAMPLE = 5'h10;
   localparam reg_ofs_t FIR_OFS_RESULT = 5'h14;

   localparam reg_ofs_t IIR_OFS_COEF   = 5'h00;
   localparam reg_ofs_t IIR_OFS_SAMPLE = 5'h04;
   localparam reg_ofs_t IIR_OFS_RESULT = 5'h08;

endpackage

`default_nettype wire

//--- design/dspsubsys.sv
// DSP tile top level that puts the FIR and IIR slaves behind one Wishbone classic port
`default_nettype none

module dspsubsys (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  dsp_bus_pkg::wb_addr_t wb_adr_i,
   input  dsp_bus_pkg::wb_data_t wb_dat_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   output dsp_bus_pkg::wb_data_t wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  wb_err_o
);

   wb_slave_if fir_bus ();                            // 0xf0000000 window
   wb_slave_if iir_bus ();                            // 0xe0000000 window

   dsp_bus_decode u_bus (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .fir_o    (fir_bus.bus),
      .iir_o    (iir_bus.bus)
   );

   fir_filter u_fir (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (fir_bus.slave)
   );

   iir_filter u_iir (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (iir_bus.slave)
   );

endmodule

`default_nettype wire

//--- design/fir_filter.sv
// Register-mapped four-tap FIR slave with one new output per sample write
`default_nettype none

module fir_filter (
   input  logic      clk,
   input  logic      rst_n_i,
   wb_slave_if.slave bus_i
);

   dsp_filter_pkg::coef_t    coef_q [dsp_filter_pkg::FIR_TAPS];
   dsp_filter_pkg::sample_t  dly_q  [dsp_filter_pkg::FIR_TAPS-1];  // Newest at index 0
   dsp_filter_pkg::sample_t  taps   [dsp_filter_pkg::FIR_TAPS];
   dsp_filter_pkg::acc_t     sum;
   dsp_filter_pkg::acc_t     result_q;
   dsp_filter_pkg::sample_t  sample_in;
   dsp_filter_pkg::coef_t    coef_in;
   dsp_filter_pkg::reg_ofs_t ofs;
   logic                     req;
   logic                     wr;
   logic                     ack_q;

   assign req       = bus_i.cyc && bus_i.stb && !ack_q;  // No new answer while acking
   assign wr        = req && bus_i.we;
   assign ofs       = {bus_i.adr[dsp_filter_pkg::OFS_MSB:dsp_filter_pkg::OFS_LSB],
                       {dsp_filter_pkg::OFS_LSB{1'b0}}};
   assign sample_in = bus_i.dat_w[dsp_filter_pkg::SAMPLE_W-1:0];
   assign coef_in   = bus_i.dat_w[dsp_filter_pkg::COEF_W-1:0];

   // Tap 0 sees the incoming sample
   always_comb begin
      taps[0] = sample_in;
      for (int i = 1; i < dsp_filter_pkg::FIR_TAPS; i++) begin
         taps[i] = dly_q[i-1];
      end
      sum = '0;                                       // Products wrap at 32 bits
      for (int i = 0; i < dsp_filter_pkg::FIR_TAPS; i++) begin
         sum = sum + dsp_filter_pkg::acc_t'(coef_q[i]) * dsp_filter_pkg::acc_t'(taps[i]);
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q    <= 1'b0;
         coef_q   <= '{default: '0};
         dly_q    <= '{default: '0};
         result_q <= '0;
      end else begin
         ack_q <= req;
         if (wr) begin
            case (ofs)
               dsp_filter_pkg::FIR_OFS_COEF0: coef_q[0] <= coef_in;
               dsp_filter_pkg::FIR_OFS_COEF1: coef_q[1] <= coef_in;
               dsp_filter_pkg::FIR_OFS_COEF2: coef_q[2] <= coef_in;
               dsp_filter_pkg::FIR_OFS_COEF3: coef_q[3] <= coef_in;
               dsp_filter_pkg::FIR_OFS_SAMPLE: begin
                  result_q <= sum;
                  dly_q[0] <= sample_in;
                  for (int i = 1; i < dsp_filter_pkg::FIR_TAPS-1; i++) begin
                     dly_q[i] <= dly_q[i-1];
                  end
               end
               default: ;                             // Result is read only
            endcase
         end
      end
   end

   // Address is held through the ack cycle
   always_comb begin
      case (ofs)
         dsp_filter_pkg::FIR_OFS_COEF0:  bus_i.dat_r = dsp_bus_pkg::wb_data_t'(coef_q[0]);
         dsp_filter_pkg::FIR_OFS_COEF1:  bus_i.dat_r = dsp_bus_pkg::wb_data_t'(coef_q[1]);
         dsp_filter_pkg::FIR_OFS_COEF2:  bus_i.dat_r = dsp_bus_pkg::wb_data_t'(coef_q[2]);
         dsp_filter_pkg::FIR_OFS_COEF3:  bus_i.dat_r = dsp_bus_pkg::wb_data_t'(coef_q[3]);
         dsp_filter_pkg::FIR_OFS_RESULT: bus_i.dat_r = dsp_bus_pkg::wb_data_t'(result_q);
         default:                        bus_i.dat_r = '0;  // Sample port is write only
      endcase
   end

   assign bus_i.ack = ack_q;
   assign bus_i.err = 1'b0;

   a_ack_single : assert property (@(posedge clk) disable iff (!rst_n_i)
      bus_i.ack |=> !bus_i.ack);

endmodule

`default_nettype wire

//--- design/iir_filter.sv
// Register-mapped first-order IIR slave with a Q15 feedback coefficient
`default_nettype none

module iir_filter (
   input  logic      clk,
   input  logic      rst_n_i,
   wb_slave_if.slave bus_i
);

   typedef logic signed [dsp_filter_pkg::COEF_W+dsp_filter_pkg::ACC_W-1:0] prod_t;

   dsp_filter_pkg::coef_t    a_q;
   dsp_filter_pkg::acc_t     y_q;                     // State and result in one
   dsp_filter_pkg::acc_t     y_next;
   dsp_filter_pkg::sample_t  sample_in;
   dsp_filter_pkg::coef_t    coef_in;
   dsp_filter_pkg::reg_ofs_t ofs;
   prod_t                    prod;
   logic                     req;
   logic                     wr;
   logic                     ack_q;

   assign req       = bus_i.cyc && bus_i.stb && !ack_q;
   assign wr        = req && bus_i.we;
   assign ofs       = {bus_i.adr[dsp_filter_pkg::OFS_MSB:dsp_filter_pkg::OFS_LSB],
                       {dsp_filter_pkg::OFS_LSB{1'b0}}};
   assign sample_in = bus_i.dat_w[dsp_filter_pkg::SAMPLE_W-1:0];
   assign coef_in   = bus_i.dat_w[dsp_filter_pkg::COEF_W-1:0];

   // Full 48-bit product before the Q15 shift
   assign prod   = prod_t'(a_q) * prod_t'(y_q);
   assign y_next = dsp_filter_pkg::acc_t'(sample_in)
                 + dsp_filter_pkg::acc_t'(prod >>> dsp_filter_pkg::IIR_FRAC_BITS);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         a_q   <= '0;
         y_q   <= '0;
      end else begin
         ack_q <= req;
         if (wr) begin
            case (ofs)
               dsp_filter_pkg::IIR_OFS_COEF:   a_q <= coef_in;
               dsp_filter_pkg::IIR_OFS_SAMPLE: y_q <= y_next;  // Wraps at 32 bits
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (ofs)
         dsp_filter_pkg::IIR_OFS_COEF:   bus_i.dat_r = dsp_bus_pkg::wb_data_t'(a_q);
         dsp_filter_pkg::IIR_OFS_RESULT: bus_i.dat_r = dsp_bus_pkg::wb_data_t'(y_q);
         default:                        bus_i.dat_r = '0;
      endcase
   end

   assign bus_i.ack = ack_q;
   assign bus_i.err = 1'b0;

   a_ack_single : assert property (@(posedge clk) disable iff (!rst_n_i)
      bus_i.ack |=> !bus_i.ack);

endmodule

`default_nettype wire

//--- design/wb_slave_if.sv
// One Wishbone classic slave channel between the address decoder and a filter
`default_nettype none

interface wb_slave_if;

   dsp_bus_pkg::wb_addr_t adr;
   dsp_bus_pkg::wb_data_t dat_w;                      // Master to slave
   logic                  cyc;
   logic                  stb;                        // Already gated by the decoder
   logic                  we;
   dsp_bus_pkg::wb_data_t dat_r;                      // Slave to master
   logic                  ack;
   logic                  err;

   modport bus (
      output adr,
      output dat_w,
      output cyc,
      output stb,
      output we,
      input  dat_r,
      input  ack,
      input  err
   );

   modport slave (
      input  adr,
      input  dat_w,
      input  cyc,
      input  stb,
      input  we,
      output dat_r,
      output ack,
      output err
   );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the DSP tile testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_dspsubsys -f src.f
out=$(./obj_dir/Vtb_dspsubsys 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "Result: PASSED"; then
   exit 0
fi
exit 1

//--- src.f
+incdir+test
design/dsp_bus_pkg.sv
design/dsp_filter_pkg.sv
design/wb_slave_if.sv
design/dsp_bus_decode.sv
design/fir_filter.sv
design/iir_filter.sv
design/dspsubsys.sv
test/tb_dspsubsys.sv

//--- test/tb_dsp_model.svh
// Filter reference models, stimulus LFSR and compare tasks, included inside the DSP tile testbench
`ifndef TB_DSP_MODEL_SVH
`define TB_DSP_MODEL_SVH

logic [31:0]             lfsr_q = 32'h2825;               // Stimulus seed
dsp_filter_pkg::coef_t   fir_coef_m [dsp_filter_pkg::FIR_TAPS] = '{default: '0};
dsp_filter_pkg::sample_t fir_hist_m [dsp_filter_pkg::FIR_TAPS-1] = '{default: '0};
dsp_filter_pkg::coef_t   iir_a_m = '0;
dsp_filter_pkg::acc_t    iir_y_m = '0;                    // Previous model output

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_take(input int nbits);
   logic [31:0] v;
   logic        b;
   v = '0;
   for (int i = 0; i < nbits; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      v = {v[30:0], b};
   end
   return v;
endfunction

// Sum of coefficient times sample, newest sample on tap 0
function automatic dsp_filter_pkg::acc_t fir_ref(input dsp_filter_pkg::sample_t x);
   dsp_filter_pkg::acc_t y;
   y = dsp_filter_pkg::acc_t'(fir_coef_m[0]) * dsp_filter_pkg::acc_t'(x);
   for (int k = 1; k < dsp_filter_pkg::FIR_TAPS; k++) begin
      y = y + dsp_filter_pkg::acc_t'(fir_coef_m[k]) * dsp_filter_pkg::acc_t'(fir_hist_m[k-1]);
   end
   for (int k = dsp_filter_pkg::FIR_TAPS - 2; k > 0; k--) begin
      fir_hist_m[k] = fir_hist_m[k-1];
   end
   fir_hist_m[0] = x;
   return y;
endfunction

// y = x + (a * y_old) >>> 15, kept to 32 bits
function automatic dsp_filter_pkg::acc_t iir_ref(input dsp_filter_pkg::sample_t x);
   longint fb;
   fb      = longint'(iir_a_m) * longint'(iir_y_m);
   iir_y_m = dsp_filter_pkg::acc_t'(longint'(x) + (fb >>> dsp_filter_pkg::IIR_FRAC_BITS));
   return iir_y_m;
endfunction

task automatic check_data(input string name, input dsp_bus_pkg::wb_data_t got,
                          input dsp_bus_pkg::wb_data_t exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
   end
endtask

task automatic check_resp(input string name, input resp_t got, input resp_t exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      stop_on_error();
   end
endtask

task automatic check_latency(input string name, input int got, input int exp);
   if (got != exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
   end
endtask

`endif

//--- test/tb_dspsubsys.sv
// Testbench for the DSP tile that drives the Wishbone port and checks both filters against models
`default_nettype none

module tb_dspsubsys;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CYCLE_LIMIT = 1000;                    // About 200 accesses of 3 cycles
   localparam int ACK_DELAY   = 2;                       // Negedges from strobe to answer
   localparam int NUM_SAMPLES = 40;

   typedef enum logic [1:0] {RESP_ACK, RESP_ERR, RESP_BOTH} resp_t;

   logic                  clk = 1'b0;
   logic                  rst_n_i;
   dsp_bus_pkg::wb_addr_t wb_adr;
   dsp_bus_pkg::wb_data_t wb_dat_w;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   dsp_bus_pkg::wb_data_t wb_dat_r;
   logic                  wb_ack;
   logic                  wb_err;
   int                    cycles = 0;

   `include "tb_dsp_model.svh"

   dspsubsys u_dspsubsys (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_dat_o (wb_dat_r),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err)
   );

   always #10 clk = ~clk;                                 // 20 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         stop_on_error();
      end
   end

   task automatic stop_on_error();
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   function automatic dsp_bus_pkg::wb_addr_t window_addr(
      input logic [dsp_bus_pkg::RANGE_WIDTH-1:0] match,
      input dsp_filter_pkg::reg_ofs_t            ofs);
      return {match, {(dsp_bus_pkg::WB_AW - dsp_bus_pkg::RANGE_WIDTH
                       - $bits(dsp_filter_pkg::reg_ofs_t)){1'b0}}, ofs};
   endfunction

   // One classic cycle held until ack or err
   task automatic bus_access(input dsp_bus_pkg::wb_addr_t adr, input logic we,
                             input dsp_bus_pkg::wb_data_t wdat, input resp_t exp,
                             output dsp_bus_pkg::wb_data_t rdat);
      int    waited;
      resp_t got;
      @(posedge clk);
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && !wb_err);
      if (wb_ack && wb_err) begin
         got = RESP_BOTH;
      end else begin
         got = wb_err ? RESP_ERR : RESP_ACK;
      end
      rdat = wb_dat_r;                                    // Valid while ack is high
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      check_resp($sformatf("wb_ack_o/wb_err_o at %h", adr), got, exp);
      check_latency($sformatf("answer delay at %h", adr), waited, ACK_DELAY);
   endtask

   task automatic wb_write(input dsp_bus_pkg::wb_addr_t adr, input dsp_bus_pkg::wb_data_t data,
                           input resp_t exp);
      dsp_bus_pkg::wb_data_t unused;
      bus_access(adr, 1'b1, data, exp, unused);
   endtask

   task automatic wb_read(input dsp_bus_pkg::wb_addr_t adr, input resp_t exp,
                          output dsp_bus_pkg::wb_data_t data);
      bus_access(adr, 1'b0, '0, exp, data);
   endtask

   task automatic run_fir_samples(input int count);
      dsp_bus_pkg::wb_data_t wdat;
      dsp_bus_pkg::wb_data_t rdat;
      dsp_filter_pkg::acc_t  exp;
      for (int n = 0; n < count; n++) begin
         wdat = lfsr_take(32);                            // Upper half is ignored
         exp  = fir_ref(dsp_filter_pkg::sample_t'(wdat[15:0]));
         wb_write(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, dsp_filter_pkg::FIR_OFS_SAMPLE),
                  wdat, RESP_ACK);
         wb_read(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, dsp_filter_pkg::FIR_OFS_RESULT),
                 RESP_ACK, rdat);
         check_data($sformatf("wb_dat_o fir result %0d", n), rdat, exp);
      end
   endtask

   task automatic run_iir_samples(input int count);
      dsp_bus_pkg::wb_data_t wdat;
      dsp_bus_pkg::wb_data_t rdat;
      dsp_filter_pkg::acc_t  exp;
      for (int n = 0; n < count; n++) begin
         wdat = lfsr_take(32);
         exp  = iir_ref(dsp_filter_pkg::sample_t'(wdat[15:0]));
         wb_write(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_SAMPLE),
                  wdat, RESP_ACK);
         wb_read(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_RESULT),
                 RESP_ACK, rdat);
         check_data($sformatf("wb_dat_o iir result %0d", n), rdat, exp);
      end
   endtask

   initial begin
      dsp_bus_pkg::wb_data_t    rdat;
      dsp_filter_pkg::coef_t    c;
      dsp_filter_pkg::reg_ofs_t ofs;
      rst_n_i  <= 1'b0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      repeat (4) @(posedge clk);
      rst_n_i <= 1'b1;

      // Everything reads zero out of reset
      wb_read(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, dsp_filter_pkg::FIR_OFS_RESULT),
              RESP_ACK, rdat);
      check_data("wb_dat_o fir result after reset", rdat, '0);
      wb_read(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_RESULT),
              RESP_ACK, rdat);
      check_data("wb_dat_o iir result after reset", rdat, '0);
      wb_read(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_COEF),
              RESP_ACK, rdat);
      check_data("wb_dat_o iir coef after reset", rdat, '0);
      for (int k = 0; k < dsp_filter_pkg::FIR_TAPS; k++) begin
         ofs = dsp_filter_pkg::reg_ofs_t'(dsp_filter_pkg::FIR_OFS_COEF0 + 4 * k);
         wb_read(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, ofs), RESP_ACK, rdat);
         check_data($sformatf("wb_dat_o fir coef%0d after reset", k), rdat, '0);
      end

      // FIR coefficients written sign extended
      for (int k = 0; k < dsp_filter_pkg::FIR_TAPS; k++) begin
         c             = dsp_filter_pkg::coef_t'(lfsr_take(16));
         fir_coef_m[k] = c;
         ofs = dsp_filter_pkg::reg_ofs_t'(dsp_filter_pkg::FIR_OFS_COEF0 + 4 * k);
         wb_write(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, ofs), {{16{c[15]}}, c}, RESP_ACK);
      end
      for (int k = 0; k < dsp_filter_pkg::FIR_TAPS; k++) begin
         c   = fir_coef_m[k];
         ofs = dsp_filter_pkg::reg_ofs_t'(dsp_filter_pkg::FIR_OFS_COEF0 + 4 * k);
         wb_read(window_addr(dsp_bus_pkg::FIR_RANGE_MATCH, ofs), RESP_ACK, rdat);
         check_data($sformatf("wb_dat_o fir coef%0d", k), rdat, {{16{c[15]}}, c});
      end
      run_fir_samples(NUM_SAMPLES);

      c       = dsp_filter_pkg::coef_t'(lfsr_take(16));
      iir_a_m = c;
      wb_write(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_COEF),
               {{16{c[15]}}, c}, RESP_ACK);
      wb_read(window_addr(dsp_bus_pkg::IIR_RANGE_MATCH, dsp_filter_pkg::IIR_OFS_COEF),
              RESP_ACK, rdat);
      check_data("wb_dat_o iir coef", rdat, {{16{c[15]}}, c});
      run_iir_samples(NUM_SAMPLES);

      // Unmapped windows whose offsets alias the sample ports
      wb_write(32'h0000_0010, lfsr_take(32), RESP_ERR);
      wb_read(32'h0000_0014, RESP_ERR, rdat);
      check_data("wb_dat_o unmapped 0x0", rdat, '0);
      wb_write(32'h9000_0004, lfsr_take(32), RESP_ERR);
      wb_read(32'h9000_0008, RESP_ERR, rdat);
      check_data("wb_dat_o unmapped 0x9", rdat, '0);
      run_fir_samples(5);                                 // History must be untouched
      run_iir_samples(5);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire
